// File: bench/tb_qr_acc_top.sv
//--------------------
// Testbench for the bit-serial accelerator top level.
// Drives the register bus, runs a table of cases through the
// engine and compares the result bytes with a reference model.
// Prints one line per test and a closing line with the counts.
//--------------------

module tb_qr_acc_top import qracc_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ROWS     = 8;
    localparam int NUM_COLS     = 4;
    localparam int READ_TIMEOUT = 8;    // Cycles to wait for rvalid
    localparam int DONE_TIMEOUT = 50;   // STATUS polls before giving up

    // Weight sets, row 0 in the lowest word, column 0 in the lowest byte
    localparam logic [255:0] W_SMALL = {4{32'hFEFF0301, 32'h05FF0301}};
    localparam logic [255:0] W_MIX   = {2{32'h7F800102, 32'hF30DE21E, 32'h01020304, 32'hC040F010}};

    typedef struct {
        string                                  name;
        qracc_config_t                          cfg;
        scaler_cfg_t                            scl;
        logic [NUM_ROWS/4-1:0][31:0]            acts;        // Bus words for the buffer
        logic [NUM_ROWS-1:0][31:0]              wrows;       // One word per weight row
        logic [NUM_COLS-1:0][OUT_BITS-1:0]      expect_res;
    } test_case_t;

    logic       clk;
    logic       rst_i;
    bus_req_t   bus_i;
    bus_rsp_t   bus_o;

    test_case_t cases[$];
    integer     seed;
    string      cur_name;
    string      abort_reason;
    event       abort_ev;
    int         test_errors;
    int         error_count;
    int         tests_run;
    int         tests_failed;

    qr_acc_top #(.NUM_ROWS(NUM_ROWS), .NUM_COLS(NUM_COLS)) i_dut (
        .clk(clk), .rst_i(rst_i), .bus_i(bus_i), .bus_o(bus_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //--------------------
    // Bus and run helpers
    //--------------------
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run(input string why);
        abort_reason = why;
        -> abort_ev;
        forever next_cycle();  // Parked until the handler ends the run
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
        bus_i.wr_en = 1'b1;
        bus_i.addr  = addr;
        bus_i.wdata = data;
        next_cycle();
        bus_i = '0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output bus_rsp_t rsp);
        int waited;
        bus_i.rd_en = 1'b1;
        bus_i.addr  = addr;
        next_cycle();
        bus_i  = '0;
        waited = 0;
        while (!bus_o.rvalid && waited < READ_TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (!bus_o.rvalid) abort_run($sformatf("Read of %04h returned no rvalid", addr));
        rsp = bus_o;
    endtask

    task automatic start_run();
        bus_write(ADDR_TRIGGER, 32'd1);
        next_cycle();  // Trigger reaches the sequencer one edge later
    endtask

    task automatic wait_done();
        bus_rsp_t rsp;
        int       polls;
        polls = 0;
        bus_read(ADDR_STATUS, rsp);
        while (!rsp.rdata[1] && polls < DONE_TIMEOUT) begin
            bus_read(ADDR_STATUS, rsp);
            polls++;
        end
        if (!rsp.rdata[1]) begin
            abort_run($sformatf("%s: done was never set after %0d polls", cur_name, polls));
        end
    endtask

    task automatic load_case(input test_case_t tc);
        bus_write(ADDR_CFG, tc.cfg);
        bus_write(ADDR_SCALE, tc.scl);
        for (int w = 0; w < NUM_ROWS/4; w++) bus_write(ADDR_ABUF + 16'(4*w), tc.acts[w]);
        for (int r = 0; r < NUM_ROWS; r++) bus_write(ADDR_WEIGHT + 16'(4*r), tc.wrows[r]);
    endtask

    //--------------------
    // Compare tasks
    //--------------------
    task automatic check_word(input string what, input logic [31:0] exp, input bus_rsp_t rsp);
        if (rsp.rdata !== exp) begin
            $display("[ERROR] %s %s: expected %08h, actual %08h", cur_name, what, exp, rsp.rdata);
            test_errors++;
        end
    endtask

    task automatic check_status(input logic exp_busy, input logic exp_done, input bus_rsp_t rsp);
        if (rsp.rdata !== {30'd0, exp_done, exp_busy}) begin
            $display("[ERROR] %s status: expected busy=%0b done=%0b, actual %08h",
                     cur_name, exp_busy, exp_done, rsp.rdata);
            test_errors++;
        end
    endtask

    task automatic check_result(input int col, input logic [OUT_BITS-1:0] exp, input bus_rsp_t rsp);
        if (rsp.rdata !== {24'd0, exp}) begin
            $display("[ERROR] %s result %0d: expected %02h, actual %08h",
                     cur_name, col, exp, rsp.rdata);
            test_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_name    = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        error_count += test_errors;
        if (test_errors == 0) begin
            $display("%s: PASS", cur_name);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", cur_name, test_errors);
        end
    endtask

    //--------------------
    // Reference model and case table
    //--------------------
    function automatic logic [NUM_COLS-1:0][OUT_BITS-1:0] model_results(input test_case_t tc);
        logic [NUM_COLS-1:0][OUT_BITS-1:0] res;
        logic [7:0]                        act;
        logic signed [7:0]                 wgt;
        int mask, acc, ai, wi, sc, val, lo, hi;
        mask = (1 << tc.cfg.input_bits) - 1;  // Activation bits above input_bits drop out
        sc   = tc.scl.scale;
        lo   = tc.cfg.unsigned_acts ? 0 : -128;
        hi   = tc.cfg.unsigned_acts ? 255 : 127;
        for (int c = 0; c < NUM_COLS; c++) begin
            acc = 0;
            for (int r = 0; r < NUM_ROWS; r++) begin
                act = tc.acts[r/4][8*(r%4) +: 8];
                wgt = tc.wrows[r][8*c +: 8];
                ai  = act;
                wi  = wgt;
                acc = acc + (ai & mask) * wi;
            end
            val = (acc * sc) >>> tc.scl.shift;
            if (val < lo) val = lo;
            else if (val > hi) val = hi;
            res[c] = val[7:0];
        end
        return res;
    endfunction

    function automatic void add_case(input string name, input logic [3:0] bits, input logic uns,
                                     input logic [7:0] sc, input logic [3:0] sh,
                                     input logic [63:0] acts, input logic [255:0] wrows);
        test_case_t tc;
        tc.name              = name;
        tc.cfg               = '0;
        tc.cfg.input_bits    = bits;
        tc.cfg.unsigned_acts = uns;
        tc.scl               = '0;
        tc.scl.scale         = sc;
        tc.scl.shift         = sh;
        tc.acts              = acts;
        tc.wrows             = wrows;
        tc.expect_res        = model_results(tc);
        cases.push_back(tc);
    endfunction

    task automatic build_table();
        logic [63:0]  acts;
        logic [255:0] w;
        logic [31:0]  r;
        add_case("u8_exact", 4'd8, 1'b1, 8'd1, 4'd0, 64'h0807060504030201, W_SMALL);
        add_case("u8_clamp", 4'd8, 1'b1, 8'd1, 4'd0, {8{8'hFF}}, {8{32'h00807F10}});
        add_case("bits1_mask", 4'd1, 1'b1, 8'd1, 4'd0, 64'hFEFFFEFFFEFFFEFF, W_SMALL);
        add_case("bits3_mask", 4'd3, 1'b1, 8'd1, 4'd0, 64'hF8F9FAFBFCFDFEFF, W_MIX);
        add_case("bits5_mask", 4'd5, 1'b1, 8'd2, 4'd1, 64'hE7C3A5817E5A3C18, W_MIX);
        add_case("signed_scale", 4'd8, 1'b0, 8'd3, 4'd4, 64'h100E0C0A08060402, W_MIX);
        add_case("signed_neg_round", 4'd4, 1'b0, 8'd200, 4'd9, 64'h0F0E0D0C0B0A0908, W_SMALL);
        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < NUM_ROWS; i++) begin
                r            = $random(seed);
                w[32*i +: 32] = r;
            end
            acts[31:0]  = $random(seed);
            acts[63:32] = $random(seed);
            r           = $random(seed);
            add_case($sformatf("random_%0d", k), 4'(r[2:0]) + 4'd1, r[3], r[15:8], r[7:4], acts, w);
        end
    endtask

    //--------------------
    // Tests
    //--------------------
    task automatic check_reset_values();
        bus_rsp_t rsp;
        begin_test("reset_values");
        bus_read(ADDR_STATUS, rsp);
        check_status(1'b0, 1'b0, rsp);
        bus_read(ADDR_CFG, rsp);
        check_word("cfg", 32'd0, rsp);
        for (int w = 0; w < NUM_ROWS/4; w++) begin
            bus_read(ADDR_ABUF + 16'(4*w), rsp);
            check_word($sformatf("abuf word %0d", w), 32'd0, rsp);
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            bus_read(ADDR_WEIGHT + 16'(4*r), rsp);
            check_word($sformatf("weight row %0d", r), 32'd0, rsp);
        end
        for (int c = 0; c < NUM_COLS; c++) begin
            bus_read(ADDR_RESULT + 16'(4*c), rsp);
            check_result(c, 8'h00, rsp);
        end
        finish_test();
    endtask

    task automatic check_readback();
        bus_rsp_t    rsp;
        logic [31:0] words [NUM_ROWS];
        begin_test("readback");
        bus_write(ADDR_CFG, 32'h0000_0015);
        bus_write(ADDR_SCALE, 32'h0000_0A37);
        bus_read(ADDR_CFG, rsp);
        check_word("cfg", 32'h0000_0015, rsp);
        bus_read(ADDR_SCALE, rsp);
        check_word("scale", 32'h0000_0A37, rsp);
        for (int r = 0; r < NUM_ROWS; r++) begin
            words[r] = $random(seed);
            bus_write(ADDR_WEIGHT + 16'(4*r), words[r]);
        end
        for (int w = 0; w < NUM_ROWS/4; w++) bus_write(ADDR_ABUF + 16'(4*w), ~words[w]);
        for (int r = 0; r < NUM_ROWS; r++) begin
            bus_read(ADDR_WEIGHT + 16'(4*r), rsp);
            check_word($sformatf("weight row %0d", r), words[r], rsp);
        end
        for (int w = 0; w < NUM_ROWS/4; w++) begin
            bus_read(ADDR_ABUF + 16'(4*w), rsp);
            check_word($sformatf("abuf word %0d", w), ~words[w], rsp);
        end
        finish_test();
    endtask

    task automatic run_case(input test_case_t tc);
        bus_rsp_t rsp;
        begin_test(tc.name);
        load_case(tc);
        start_run();
        wait_done();
        bus_read(ADDR_STATUS, rsp);
        check_status(1'b0, 1'b1, rsp);
        for (int c = 0; c < NUM_COLS; c++) begin
            bus_read(ADDR_RESULT + 16'(4*c), rsp);
            check_result(c, tc.expect_res[c], rsp);
        end
        finish_test();
    endtask

    // Done from the previous case must clear on the new trigger
    task automatic check_status_flow(input test_case_t tc);
        bus_rsp_t rsp;
        begin_test("status_run");
        load_case(tc);
        start_run();
        bus_read(ADDR_STATUS, rsp);
        check_status(1'b1, 1'b0, rsp);
        bus_write(ADDR_ABUF, ~tc.acts[0]);       // Operands already captured
        bus_write(ADDR_ABUF + 16'd4, ~tc.acts[1]);
        bus_write(ADDR_TRIGGER, 32'd1);          // Dropped while busy
        wait_done();
        for (int c = 0; c < NUM_COLS; c++) begin
            bus_read(ADDR_RESULT + 16'(4*c), rsp);
            check_result(c, tc.expect_res[c], rsp);
        end
        repeat (4) next_cycle();
        bus_read(ADDR_STATUS, rsp);
        check_status(1'b0, 1'b1, rsp);
        finish_test();
    endtask

    initial begin : abort_handler
        @(abort_ev);
        $display("%s", abort_reason);
        $display("** FAIL **");
        $finish;
    end

    initial begin : main
        rst_i        = 1'b1;
        bus_i        = '0;
        seed         = 32'hcdd03b90;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        build_table();
        repeat (10) @(posedge clk);
        #1 rst_i = 1'b0;
        check_reset_values();
        check_readback();
        foreach (cases[i]) run_case(cases[i]);
        check_status_flow(cases[0]);
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: hdl/activation_buffer.sv
//--------------------
// Activation store of byte elements.
// Each bus word fills four elements, lowest byte first.
// The engine sees every element in parallel at all times.
//--------------------

module activation_buffer import qracc_pkg::*; #(
    parameter int NUM_ROWS = 8
) (
    input  logic                                clk,
    input  logic                                rst_i,
    input  bus_req_t                            bus_i,
    output logic [NUM_ROWS-1:0][ELEM_BITS-1:0]  data_o,
    output logic [31:0]                         rdata_o
);

    localparam int NUM_WORDS = NUM_ROWS / 4;

    logic       in_win;
    logic [5:0] word_idx;

    assign in_win   = (bus_i.addr[15:8] == ADDR_ABUF[15:8]);
    assign word_idx = bus_i.addr[7:2];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            data_o <= '0;
        end else if (bus_i.wr_en && in_win) begin
            for (int w = 0; w < NUM_WORDS; w++) begin
                if (word_idx == w) data_o[4*w +: 4] <= bus_i.wdata;
            end
        end
    end

    // Word readback, out of range words read zero
    always_ff @(posedge clk) begin
        if (bus_i.rd_en) begin
            rdata_o <= '0;
            for (int w = 0; w < NUM_WORDS; w++) begin
                if (in_win && (word_idx == w)) rdata_o <= data_o[4*w +: 4];
            end
        end
    end

endmodule

// File: hdl/output_scaler.sv
//--------------------
// Fixed-point output scaler.
// Per column: accumulator times scale, arithmetic shift right,
// clamp to 0..255 or -128..127. Results are held until the next run
// and read back as raw bytes at ADDR_RESULT + 4c.
//--------------------

module output_scaler import qracc_pkg::*; #(
    parameter int NUM_COLS = 4
) (
    input  logic                               clk,
    input  logic                               rst_i,
    input  qracc_config_t                      cfg_i,
    input  scaler_cfg_t                        scale_i,
    input  logic                               acc_valid_i,
    input  logic [NUM_COLS-1:0][ACC_BITS-1:0]  acc_data_i,
    output logic                               scaled_valid_o,
    input  bus_req_t                           bus_i,
    output logic [31:0]                        rdata_o
);

    localparam int PROD_BITS = ACC_BITS + 9;  // Scale gets a zero sign bit

    logic signed [PROD_BITS-1:0]         shifted [NUM_COLS];
    logic signed [PROD_BITS-1:0]         lo_lim;
    logic signed [PROD_BITS-1:0]         hi_lim;
    logic [NUM_COLS-1:0][OUT_BITS-1:0]   clamped;
    logic [NUM_COLS-1:0][OUT_BITS-1:0]   result_q;

    assign lo_lim = cfg_i.unsigned_acts ? '0 : -(1 <<< (OUT_BITS-1));
    assign hi_lim = cfg_i.unsigned_acts ? (1 << OUT_BITS) - 1 : (1 << (OUT_BITS-1)) - 1;

    always_comb begin
        for (int c = 0; c < NUM_COLS; c++) begin
            shifted[c] = ($signed(acc_data_i[c]) * $signed({1'b0, scale_i.scale})) >>> scale_i.shift;
            if (shifted[c] < lo_lim)      clamped[c] = OUT_BITS'(lo_lim);
            else if (shifted[c] > hi_lim) clamped[c] = OUT_BITS'(hi_lim);
            else                          clamped[c] = OUT_BITS'(shifted[c]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            result_q       <= '0;
            scaled_valid_o <= 1'b0;
        end else begin
            scaled_valid_o <= acc_valid_i;
            if (acc_valid_i) result_q <= clamped;
        end
    end

    // Result readback, zero extended
    always_ff @(posedge clk) begin
        if (bus_i.rd_en) begin
            rdata_o <= '0;
            for (int c = 0; c < NUM_COLS; c++) begin
                if ((bus_i.addr[15:8] == ADDR_RESULT[15:8]) && (bus_i.addr[7:2] == c)) begin
                    rdata_o <= {24'd0, result_q[c]};
                end
            end
        end
    end

endmodule

// File: hdl/qr_acc_top.sv
//--------------------
// Top level of the bit-serial accelerator.
// Connects CSRs, stores, engine, scaler and sequencer to the
// register bus and returns read data one cycle after rd_en.
//--------------------

module qr_acc_top import qracc_pkg::*; #(
    parameter int NUM_ROWS = 8,
    parameter int NUM_COLS = 4
) (
    input  logic     clk,
    input  logic     rst_i,
    input  bus_req_t bus_i,
    output bus_rsp_t bus_o
);

    //--------------------
    // Signals
    //--------------------
    qracc_config_t cfg;
    scaler_cfg_t   scale;
    logic          trigger, busy, done, start;
    logic          acc_valid, scaled_valid;

    logic [NUM_ROWS-1:0][ELEM_BITS-1:0]               abuf_data;
    logic [NUM_ROWS-1:0][NUM_COLS-1:0][ELEM_BITS-1:0] weights;
    logic [NUM_COLS-1:0][ACC_BITS-1:0]                acc_data;

    logic [31:0] csr_rdata, abuf_rdata, wgt_rdata, res_rdata;
    logic        rd_q;
    logic [7:0]  win_q;  // Address window of the pending read

    //--------------------
    // Blocks
    //--------------------
    qracc_csr u_csr (
        .clk(clk), .rst_i(rst_i), .bus_i(bus_i), .busy_i(busy), .done_i(done),
        .cfg_o(cfg), .scale_o(scale), .trigger_o(trigger), .rdata_o(csr_rdata)
    );

    activation_buffer #(.NUM_ROWS(NUM_ROWS)) u_abuf (
        .clk(clk), .rst_i(rst_i), .bus_i(bus_i), .data_o(abuf_data), .rdata_o(abuf_rdata)
    );

    weight_array #(.NUM_ROWS(NUM_ROWS), .NUM_COLS(NUM_COLS)) u_weights (
        .clk(clk), .rst_i(rst_i), .bus_i(bus_i), .weight_o(weights), .rdata_o(wgt_rdata)
    );

    qracc_controller u_ctrl (
        .clk(clk), .rst_i(rst_i), .trigger_i(trigger), .scaled_valid_i(scaled_valid),
        .busy_o(busy), .done_o(done), .start_o(start)
    );

    seq_acc #(.NUM_ROWS(NUM_ROWS), .NUM_COLS(NUM_COLS)) u_seq_acc (
        .clk(clk), .rst_i(rst_i), .cfg_i(cfg), .start_i(start),
        .act_i(abuf_data), .weight_i(weights),
        .acc_valid_o(acc_valid), .acc_data_o(acc_data)
    );

    output_scaler #(.NUM_COLS(NUM_COLS)) u_scaler (
        .clk(clk), .rst_i(rst_i), .cfg_i(cfg), .scale_i(scale),
        .acc_valid_i(acc_valid), .acc_data_i(acc_data), .scaled_valid_o(scaled_valid),
        .bus_i(bus_i), .rdata_o(res_rdata)
    );

    //--------------------
    // Read return
    //--------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rd_q  <= 1'b0;
            win_q <= '0;
        end else begin
            rd_q  <= bus_i.rd_en;
            win_q <= bus_i.addr[15:8];
        end
    end

    always_comb begin
        bus_o.rvalid = rd_q;
        case (win_q)
            ADDR_CFG[15:8]:    bus_o.rdata = csr_rdata;
            ADDR_ABUF[15:8]:   bus_o.rdata = abuf_rdata;
            ADDR_WEIGHT[15:8]: bus_o.rdata = wgt_rdata;
            ADDR_RESULT[15:8]: bus_o.rdata = res_rdata;
            default:           bus_o.rdata = '0;  // Unmapped
        endcase
    end

endmodule

// File: hdl/qracc_controller.sv
//--------------------
// Run sequencer.
// Idle accepts a trigger, run issues the engine start pulse,
// wait holds busy until the scaled results land.
// Done is sticky until the next accepted trigger.
//--------------------

module qracc_controller (
    input  logic clk,
    input  logic rst_i,
    input  logic trigger_i,
    input  logic scaled_valid_i,
    output logic busy_o,
    output logic done_o,
    output logic start_o
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_RUN  = 2'd1;
    localparam logic [1:0] ST_WAIT = 2'd2;

    logic [1:0] state;
    logic [1:0] state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: if (trigger_i) state_nxt = ST_RUN;  // Triggers while busy are dropped
            ST_RUN:  state_nxt = ST_WAIT;               // Start lasts one cycle
            ST_WAIT: if (scaled_valid_i) state_nxt = ST_IDLE;
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state  <= ST_IDLE;
            done_o <= 1'b0;
        end else begin
            state <= state_nxt;
            if ((state == ST_IDLE) && trigger_i) begin
                done_o <= 1'b0;
            end else if ((state == ST_WAIT) && scaled_valid_i) begin
                done_o <= 1'b1;
            end
        end
    end

    assign busy_o  = (state != ST_IDLE);
    assign start_o = (state == ST_RUN);

endmodule

// File: hdl/qracc_csr.sv
//--------------------
// Configuration and status registers.
// Decodes CFG, SCALE, TRIGGER and STATUS on the register bus,
// drives the run configuration and a one-cycle trigger pulse.
// Readback is registered, one cycle after the read strobe.
//--------------------

module qracc_csr import qracc_pkg::*; (
    input  logic          clk,
    input  logic          rst_i,
    input  bus_req_t      bus_i,
    input  logic          busy_i,
    input  logic          done_i,
    output qracc_config_t cfg_o,
    output scaler_cfg_t   scale_o,
    output logic          trigger_o,
    output logic [31:0]   rdata_o
);

    csr_word_u   wr_word;
    logic [31:0] status_word;

    assign wr_word     = bus_i.wdata;
    assign status_word = {30'd0, done_i, busy_i};

    //--------------------
    // Write side
    //--------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            cfg_o     <= '0;
            scale_o   <= '0;
            trigger_o <= 1'b0;
        end else begin
            // Any value written to TRIGGER fires one pulse
            trigger_o <= bus_i.wr_en && (bus_i.addr == ADDR_TRIGGER);
            if (bus_i.wr_en && (bus_i.addr == ADDR_CFG)) begin
                cfg_o <= wr_word.cfg;
            end
            if (bus_i.wr_en && (bus_i.addr == ADDR_SCALE)) begin
                scale_o <= wr_word.scale;
            end
        end
    end

    //--------------------
    // Readback
    //--------------------
    always_ff @(posedge clk) begin
        if (bus_i.rd_en) begin
            case (bus_i.addr)
                ADDR_CFG:    rdata_o <= cfg_o;
                ADDR_SCALE:  rdata_o <= scale_o;
                ADDR_STATUS: rdata_o <= status_word;
                default:     rdata_o <= '0;  // TRIGGER and holes read zero
            endcase
        end
    end

endmodule

// File: hdl/qracc_pkg.sv
//--------------------
// Shared types and constants for the bit-serial accelerator.
// Holds the register bus structs, the configuration words,
// the CSR write union and the address map.
// Modules pull it in with a wildcard import in their header.
//--------------------

package qracc_pkg;

    //--------------------
    // Widths
    //--------------------
    localparam int ELEM_BITS = 8;   // Activation and weight element
    localparam int ACC_BITS  = 20;  // Holds 8 x 255 x 128 with sign
    localparam int OUT_BITS  = 8;   // Scaled result

    //--------------------
    // Address map
    //--------------------
    localparam logic [15:0] ADDR_CFG     = 16'h000;
    localparam logic [15:0] ADDR_SCALE   = 16'h004;
    localparam logic [15:0] ADDR_TRIGGER = 16'h008;
    localparam logic [15:0] ADDR_STATUS  = 16'h00C;
    localparam logic [15:0] ADDR_ABUF    = 16'h100;  // Two words
    localparam logic [15:0] ADDR_WEIGHT  = 16'h200;  // One word per row
    localparam logic [15:0] ADDR_RESULT  = 16'h300;  // One word per column

    // One request per cycle, plain strobes
    typedef struct packed {
        logic        wr_en;
        logic        rd_en;
        logic [15:0] addr;   // Byte address
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic        rvalid;
        logic [31:0] rdata;
    } bus_rsp_t;

    // Run configuration
    typedef struct packed {
        logic [26:0] spare;
        logic        unsigned_acts;  // Clamp to 0..255 instead of -128..127
        logic [3:0]  input_bits;     // 1 to 8
    } qracc_config_t;

    // Output scaler setting
    typedef struct packed {
        logic [19:0] spare;
        logic [3:0]  shift;
        logic [7:0]  scale;          // Unsigned multiplier
    } scaler_cfg_t;

    // Same write word, two views picked by register address
    typedef union packed {
        qracc_config_t cfg;
        scaler_cfg_t   scale;
    } csr_word_u;

endpackage

// File: hdl/seq_acc.sv
//--------------------
// Bit-serial multiply-accumulate engine.
// Captures activations and weights on start, then walks the
// activation bits from input_bits-1 down to 0, one per cycle.
// Each step doubles the column sums and adds the weights of
// rows whose current activation bit is set.
//--------------------

module seq_acc import qracc_pkg::*; #(
    parameter int NUM_ROWS = 8,
    parameter int NUM_COLS = 4
) (
    input  logic                                              clk,
    input  logic                                              rst_i,
    input  qracc_config_t                                     cfg_i,
    input  logic                                              start_i,
    input  logic [NUM_ROWS-1:0][ELEM_BITS-1:0]                act_i,
    input  logic [NUM_ROWS-1:0][NUM_COLS-1:0][ELEM_BITS-1:0]  weight_i,
    output logic                                              acc_valid_o,
    output logic [NUM_COLS-1:0][ACC_BITS-1:0]                 acc_data_o
);

    localparam int CNT_BITS = $clog2(ELEM_BITS);

    logic [NUM_ROWS-1:0][ELEM_BITS-1:0]               act_q;
    logic [NUM_ROWS-1:0][NUM_COLS-1:0][ELEM_BITS-1:0] weight_q;
    logic [CNT_BITS-1:0]                              bit_cnt;
    logic                                             running;
    logic signed [ACC_BITS-1:0]                       col_sum [NUM_COLS];

    //--------------------
    // Partial sums for the current bit
    //--------------------
    always_comb begin
        for (int c = 0; c < NUM_COLS; c++) begin
            col_sum[c] = '0;
            for (int r = 0; r < NUM_ROWS; r++) begin
                if (act_q[r][bit_cnt]) begin
                    col_sum[c] = col_sum[c] + $signed(weight_q[r][c]);  // Sign extended
                end
            end
        end
    end

    //--------------------
    // Control
    //--------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            running     <= 1'b0;
            bit_cnt     <= '0;
            acc_valid_o <= 1'b0;
        end else begin
            acc_valid_o <= running && (bit_cnt == '0);
            if (start_i) begin
                running <= 1'b1;
                bit_cnt <= CNT_BITS'(cfg_i.input_bits - 4'd1);  // MSB first
            end else if (running) begin
                if (bit_cnt == '0) running <= 1'b0;
                else bit_cnt <= bit_cnt - 1'b1;
            end
        end
    end

    // Operands and accumulators
    always_ff @(posedge clk) begin
        if (start_i) begin
            act_q      <= act_i;
            weight_q   <= weight_i;
            acc_data_o <= '0;
        end else if (running) begin
            for (int c = 0; c < NUM_COLS; c++) begin
                acc_data_o[c] <= {acc_data_o[c][ACC_BITS-2:0], 1'b0} + col_sum[c];
            end
        end
    end

endmodule

// File: hdl/weight_array.sv
//--------------------
// Signed weight store, NUM_ROWS by NUM_COLS bytes.
// One bus word per group of four columns of a row.
//--------------------

module weight_array import qracc_pkg::*; #(
    parameter int NUM_ROWS = 8,
    parameter int NUM_COLS = 4
) (
    input  logic                                              clk,
    input  logic                                              rst_i,
    input  bus_req_t                                          bus_i,
    output logic [NUM_ROWS-1:0][NUM_COLS-1:0][ELEM_BITS-1:0]  weight_o,
    output logic [31:0]                                       rdata_o
);

    localparam int GROUPS = NUM_COLS / 4;  // Words per row

    logic       in_win;
    logic [5:0] word_idx;

    assign in_win   = (bus_i.addr[15:8] == ADDR_WEIGHT[15:8]);
    assign word_idx = bus_i.addr[7:2];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            weight_o <= '0;
        end else if (bus_i.wr_en && in_win) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                for (int g = 0; g < GROUPS; g++) begin
                    if (word_idx == r*GROUPS + g) weight_o[r][4*g +: 4] <= bus_i.wdata;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus_i.rd_en) begin
            rdata_o <= '0;
            for (int r = 0; r < NUM_ROWS; r++) begin
                for (int g = 0; g < GROUPS; g++) begin
                    if (in_win && (word_idx == r*GROUPS + g)) rdata_o <= weight_o[r][4*g +: 4];
                end
            end
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line.
# Exits non-zero when the build fails or the pass line is missing.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_qr_acc_top -f verilog.f \
    && ./obj_dir/Vtb_qr_acc_top | tee /dev/stderr | grep -Fxq '** PASS **' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: verilog.f
hdl/qracc_pkg.sv
hdl/qracc_csr.sv
hdl/activation_buffer.sv
hdl/weight_array.sv
hdl/seq_acc.sv
hdl/output_scaler.sv
hdl/qracc_controller.sv
hdl/qr_acc_top.sv
bench/tb_qr_acc_top.sv
